// ==== hdl/pong_pkg.sv ====
// shared pong geometry and types; 4x4 sprites on a 320x240 field, ball speed fixed at 2 per axis
package pong_pkg;

	// field and sprite geometry in pixels
	localparam int SCREEN_W      = 320;
	localparam int SCREEN_H      = 240;
	localparam int SPRITE        = 4;
	localparam int SPRITE_PIXELS = SPRITE * SPRITE; // 16 pixels per sprite
	localparam int BALL_STEP     = 2;               // per frame, both axes

	typedef logic [8:0] x_t;      // column 0..319
	typedef logic [7:0] y_t;      // row 0..239
	typedef logic [2:0] colour_t; // rgb, one bit each
	typedef logic [3:0] score_t;
	typedef logic [6:0] seg7_t;   // active low, segment a in bit 0

	// largest top-left corner that keeps a sprite on screen
	localparam x_t X_MAX = x_t'(SCREEN_W - SPRITE); // 316
	localparam y_t Y_MAX = y_t'(SCREEN_H - SPRITE); // 236

	// serve and start positions
	localparam x_t BALL_START_X = x_t'(156);
	localparam y_t BALL_START_Y = y_t'(116);
	localparam y_t PAD_START_Y  = y_t'(116);

	localparam colour_t BG_COLOUR   = 3'd0; // black
	localparam colour_t BALL_COLOUR = 3'd2; // green
	localparam colour_t PAD_COLOUR  = 3'd7; // white

	// sprite top-left corner
	typedef struct packed {
		x_t x;
		y_t y;
	} pos_t;

	// one pixel for the frame-buffer writer
	typedef struct packed {
		x_t      x;
		y_t      y;
		colour_t colour;
	} pixel_t;

	// player command, up low means down
	typedef struct packed {
		logic go;
		logic up;
		logic speed; // two rows per step instead of one
	} pad_cmd_t;

	// who scored on this step
	typedef struct packed {
		logic left;
		logic right;
	} point_t;

endpackage

// ==== hdl/pong_sequencer.sv ====
// frame FSM erase, step, draw, wait; FRAME_TICKS counts only idle time, never ack stalls
`timescale 1ns/1ps

module pong_sequencer import pong_pkg::*; #(
	parameter int FRAME_TICKS = 833333,
	parameter int LEFT_PAD_X  = 2,
	parameter int RIGHT_PAD_X = 314
) (
	input  logic   clk,
	input  logic   reset,
	input  logic   serve_i,
	input  point_t point_i,
	input  logic   game_over_i,
	input  pos_t   ball_i,
	input  y_t     pad_l_y_i,
	input  y_t     pad_r_y_i,
	input  logic   ack_i,
	output logic   step_o,
	output logic   req_o,
	output pixel_t pixel_o
);

	localparam int TW = $clog2(FRAME_TICKS + 1);
	localparam logic [5:0] LAST_PIX = 6'(3 * SPRITE_PIXELS - 1); // 48 pixels per phase

	typedef enum logic [2:0] {
		S_SERVE,
		S_ERASE,
		S_STEP,
		S_DRAW,
		S_WAIT,
		S_OVER
	} state_t;

	state_t        state;
	logic [5:0]    cnt;    // [5:4] sprite, [3:2] row offset, [1:0] column offset
	logic [TW-1:0] timer;
	logic          scored; // this frame's step gave a point
	pos_t          origin;

	assign step_o = (state == S_STEP);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state  <= S_SERVE;
			req_o  <= 1'b0;
			cnt    <= '0;
			timer  <= '0;
			scored <= 1'b0;
		end
		else
		begin
			case (state)
				S_SERVE:
					if (serve_i)
					begin
						state <= S_ERASE;
						req_o <= 1'b1; // first erase request next cycle
						cnt   <= '0;
					end
				S_ERASE, S_DRAW:
					if (req_o)
					begin
						if (ack_i)
							req_o <= 1'b0; // phase 3 of the handshake
					end
					else if (!ack_i) // writer released ack
					begin
						if (cnt != LAST_PIX)
						begin
							cnt   <= cnt + 6'd1;
							req_o <= 1'b1;
						end
						else if (state == S_ERASE)
							state <= S_STEP;
						else if (game_over_i)
							state <= S_OVER;
						else if (scored)
							state <= S_SERVE; // wait for the next serve
						else
						begin
							state <= S_WAIT;
							timer <= TW'(FRAME_TICKS - 1);
						end
					end
				S_STEP:
				begin
					state  <= S_DRAW;
					req_o  <= 1'b1;
					cnt    <= '0;
					scored <= point_i.left | point_i.right; // flags are valid on step only
				end
				S_WAIT:
					if (timer == '0)
					begin
						state <= S_ERASE;
						req_o <= 1'b1;
						cnt   <= '0;
					end
					else
						timer <= timer - 1'b1;
				default:
					state <= S_OVER; // game over holds until reset
			endcase
		end
	end

	// sprite origin: ball, left paddle, right paddle
	always_comb
	begin
		case (cnt[5:4])
			2'd0:
				origin = ball_i;
			2'd1:
				origin = '{x: x_t'(LEFT_PAD_X), y: pad_l_y_i};
			default:
				origin = '{x: x_t'(RIGHT_PAD_X), y: pad_r_y_i};
		endcase
		pixel_o.x = origin.x + x_t'(cnt[1:0]); // raster order inside the sprite
		pixel_o.y = origin.y + y_t'(cnt[3:2]);
		if (state == S_ERASE)
			pixel_o.colour = BG_COLOUR;
		else if (cnt[5:4] == 2'd0)
			pixel_o.colour = BALL_COLOUR;
		else
			pixel_o.colour = PAD_COLOUR;
	end

endmodule

// ==== hdl/ball_mover.sv ====
// ball position and velocity; speed is always 2, coordinates stay even so no clamping is done
`timescale 1ns/1ps

module ball_mover import pong_pkg::*; #(
	parameter int LEFT_PAD_X  = 2,
	parameter int RIGHT_PAD_X = 314
) (
	input  logic   clk,
	input  logic   reset,
	input  logic   step_i,
	input  y_t     pad_l_y_i,
	input  y_t     pad_r_y_i,
	output pos_t   ball_o,
	output point_t point_o
);

	// column where the ball touches a paddle face
	localparam x_t HIT_L = x_t'(LEFT_PAD_X + SPRITE);
	localparam x_t HIT_R = x_t'(RIGHT_PAD_X - SPRITE);

	logic dx_neg; // moving left
	logic dy_neg; // moving up
	logic miss_l, miss_r;
	logic flip_x, flip_y;
	logic dx_n, dy_n;

	// rows overlap within 3 pixels, widened so +3 cannot wrap
	function automatic logic near(input y_t a, input y_t b);
		return ({1'b0, a} + 9'd3 >= {1'b0, b}) && ({1'b0, b} + 9'd3 >= {1'b0, a});
	endfunction

	assign miss_l = (ball_o.x == '0) && dx_neg;     // right player scores
	assign miss_r = (ball_o.x == X_MAX) && !dx_neg; // left player scores
	assign point_o.left  = step_i && miss_r;
	assign point_o.right = step_i && miss_l;

	assign flip_y = ((ball_o.y == '0) && dy_neg) || ((ball_o.y == Y_MAX) && !dy_neg);
	assign flip_x = ((ball_o.x == HIT_L) && dx_neg && near(ball_o.y, pad_l_y_i))
		|| ((ball_o.x == HIT_R) && !dx_neg && near(ball_o.y, pad_r_y_i));
	assign dx_n = dx_neg ^ flip_x;
	assign dy_n = dy_neg ^ flip_y;

	always_ff @(posedge clk)
	begin
		if (reset || (step_i && (miss_l || miss_r)))
		begin
			// serve from the centre, heading left and down
			ball_o <= '{x: BALL_START_X, y: BALL_START_Y};
			dx_neg <= 1'b1;
			dy_neg <= 1'b0;
		end
		else if (step_i)
		begin
			dx_neg <= dx_n;
			dy_neg <= dy_n;
			ball_o.x <= dx_n ? ball_o.x - x_t'(BALL_STEP) : ball_o.x + x_t'(BALL_STEP);
			ball_o.y <= dy_n ? ball_o.y - y_t'(BALL_STEP) : ball_o.y + y_t'(BALL_STEP);
		end
	end

endmodule

// ==== hdl/paddle_mover.sv ====
// one paddle row; command sampled only on step, a point overrides the move with the start row
`timescale 1ns/1ps

module paddle_mover import pong_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     step_i,
	input  logic     restart_i,
	input  pad_cmd_t cmd_i,
	output y_t       y_o
);

	y_t amt; // rows to move this step

	always_comb
	begin
		if (!cmd_i.go)
			amt = y_t'(0);
		else if (cmd_i.speed)
			amt = y_t'(2);
		else
			amt = y_t'(1);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			y_o <= PAD_START_Y;
		else if (step_i)
		begin
			if (restart_i)
				y_o <= PAD_START_Y; // back to centre after any point
			else if (cmd_i.up)
				y_o <= (y_o < amt) ? y_t'(0) : y_o - amt; // stop at the top wall
			else if (y_o > Y_MAX - amt)
				y_o <= Y_MAX; // stop at the bottom wall
			else
				y_o <= y_o + amt;
		end
	end

endmodule

// ==== hdl/score_board.sv ====
// two hex score digits; scores freeze once one reaches WIN_SCORE, only reset starts a new game
`timescale 1ns/1ps

module score_board import pong_pkg::*; #(
	parameter int WIN_SCORE = 11
) (
	input  logic   clk,
	input  logic   reset,
	input  point_t point_i,
	output seg7_t  seg_l_o,
	output seg7_t  seg_r_o,
	output logic   game_over_o
);

	localparam score_t WIN = score_t'(WIN_SCORE);

	score_t score_l;
	score_t score_r;

	// active low, bit 0 is segment a
	function automatic seg7_t seg7(input score_t d);
		case (d)
			4'h0: return 7'b100_0000;
			4'h1: return 7'b111_1001;
			4'h2: return 7'b010_0100;
			4'h3: return 7'b011_0000;
			4'h4: return 7'b001_1001;
			4'h5: return 7'b001_0010;
			4'h6: return 7'b000_0010;
			4'h7: return 7'b111_1000;
			4'h8: return 7'b000_0000;
			4'h9: return 7'b001_1000;
			4'hA: return 7'b000_1000;
			4'hB: return 7'b000_0011;
			4'hC: return 7'b100_0110;
			4'hD: return 7'b010_0001;
			4'hE: return 7'b000_0110;
			default: return 7'b000_1110; // F
		endcase
	endfunction

	assign game_over_o = (score_l == WIN) || (score_r == WIN); // level, counters stop here

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			score_l <= '0;
			score_r <= '0;
		end
		else if (!game_over_o)
		begin
			if (point_i.left)
				score_l <= score_l + 4'd1;
			if (point_i.right)
				score_r <= score_r + 4'd1;
		end
	end

	assign seg_l_o = seg7(score_l);
	assign seg_r_o = seg7(score_r);

endmodule

// ==== hdl/pong_top.sv ====
// pong engine top; pixels leave over a four-phase req/ack port, a slow ack stalls the game
`timescale 1ns/1ps

module pong_top import pong_pkg::*; #(
	parameter int FRAME_TICKS = 833333, // idle cycles between frames
	parameter int LEFT_PAD_X  = 2,
	parameter int RIGHT_PAD_X = 314,
	parameter int WIN_SCORE   = 11
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     serve_i,
	input  pad_cmd_t pad_l_i,
	input  pad_cmd_t pad_r_i,
	input  logic     ack_i,
	output logic     req_o,
	output pixel_t   pixel_o,
	output seg7_t    seg_l_o,
	output seg7_t    seg_r_o,
	output logic     game_over_o
);

	logic   step;     // one update per frame
	logic   restart;  // any point sends paddles home
	point_t point;
	pos_t   ball;
	y_t     pad_l_y;
	y_t     pad_r_y;

	assign restart = point.left | point.right;

	pong_sequencer #(
		.FRAME_TICKS (FRAME_TICKS),
		.LEFT_PAD_X  (LEFT_PAD_X),
		.RIGHT_PAD_X (RIGHT_PAD_X)
	) u_seq (
		.clk         (clk),
		.reset       (reset),
		.serve_i     (serve_i),
		.point_i     (point),
		.game_over_i (game_over_o),
		.ball_i      (ball),
		.pad_l_y_i   (pad_l_y),
		.pad_r_y_i   (pad_r_y),
		.ack_i       (ack_i),
		.step_o      (step),
		.req_o       (req_o),
		.pixel_o     (pixel_o)
	);

	ball_mover #(
		.LEFT_PAD_X  (LEFT_PAD_X),
		.RIGHT_PAD_X (RIGHT_PAD_X)
	) u_ball (
		.clk       (clk),
		.reset     (reset),
		.step_i    (step),
		.pad_l_y_i (pad_l_y),
		.pad_r_y_i (pad_r_y),
		.ball_o    (ball),
		.point_o   (point)
	);

	// same mover for both sides, column only matters for drawing and bounces
	paddle_mover u_pad_l (
		.clk       (clk),
		.reset     (reset),
		.step_i    (step),
		.restart_i (restart),
		.cmd_i     (pad_l_i),
		.y_o       (pad_l_y)
	);

	paddle_mover u_pad_r (
		.clk       (clk),
		.reset     (reset),
		.step_i    (step),
		.restart_i (restart),
		.cmd_i     (pad_r_i),
		.y_o       (pad_r_y)
	);

	score_board #(
		.WIN_SCORE (WIN_SCORE)
	) u_score (
		.clk         (clk),
		.reset       (reset),
		.point_i     (point),
		.seg_l_o     (seg_l_o),
		.seg_r_o     (seg_r_o),
		.game_over_o (game_over_o)
	);

endmodule

// ==== test/pong_asserts.sv ====
// handshake checks bound into pong_sequencer; all checks are idle while reset is high
`timescale 1ns/1ps

module pong_asserts import pong_pkg::*; (
	input logic   clk,
	input logic   reset,
	input logic   req_o,
	input logic   ack_i,
	input pixel_t pixel_o
);

	// pixel held for the whole request
	assert property (@(posedge clk) disable iff (reset)
		req_o && $past(req_o) |-> pixel_o == $past(pixel_o))
		else $error("pixel_o changed during a request");

	// req only drops after ack
	assert property (@(posedge clk) disable iff (reset)
		$past(req_o) && !$past(ack_i) |-> req_o)
		else $error("req_o dropped without ack_i");

	// new request only once ack is low
	assert property (@(posedge clk) disable iff (reset)
		req_o && !$past(req_o) |-> !$past(ack_i))
		else $error("req_o rose while ack_i was high");

endmodule

bind pong_sequencer pong_asserts u_asserts (
	.clk     (clk),
	.reset   (reset),
	.req_o   (req_o),
	.ack_i   (ack_i),
	.pixel_o (pixel_o)
);

// ==== test/pong_tb.sv ====
// pong testbench; reads test/pong_golden.txt from the project root, ack answers after 0..3 cycles
`timescale 1ns/1ps

module pong_tb import pong_pkg::*; ();

	localparam int FRAME_TICKS = 16;
	localparam int LEFT_PAD_X  = 2;
	localparam int RIGHT_PAD_X = 314;
	localparam int WIN_SCORE   = 3;
	localparam int MAX_SEG     = 32;
	localparam int COLS        = 15;
	localparam int IDLE_CYCLES = 200; // quiet time for segments without frames

	logic     clk;
	logic     reset;
	logic     serve;
	logic     ack;
	logic     req;
	logic     game_over;
	pad_cmd_t pad_l;
	pad_cmd_t pad_r;
	pixel_t   pixel;
	seg7_t    seg_l;
	seg7_t    seg_r;

	int gold [MAX_SEG][COLS]; // one row per segment
	int n_seg;
	int errors;
	int checks;
	int limit_cycles;
	int org_x [3]; // last drawn origin of ball, left and right
	int org_y [3];

	pong_top #(
		.FRAME_TICKS (FRAME_TICKS),
		.LEFT_PAD_X  (LEFT_PAD_X),
		.RIGHT_PAD_X (RIGHT_PAD_X),
		.WIN_SCORE   (WIN_SCORE)
	) DUT (
		.clk         (clk),
		.reset       (reset),
		.serve_i     (serve),
		.pad_l_i     (pad_l),
		.pad_r_i     (pad_r),
		.ack_i       (ack),
		.req_o       (req),
		.pixel_o     (pixel),
		.seg_l_o     (seg_l),
		.seg_r_o     (seg_r),
		.game_over_o (game_over)
	);

	initial
		clk = 1'b0;
	always #2 clk = ~clk; // 4 ns period

	task automatic check(input string name, input int got, input int exp);
		checks++;
		if (got != exp)
		begin
			errors++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	// hex digit on active low segments with a in bit 0
	function automatic int digit_segments(input int d);
		case (d)
			0: return 'h40;
			1: return 'h79;
			2: return 'h24;
			3: return 'h30;
			default: return 'h7f; // blank, never expected
		endcase
	endfunction

	function automatic pad_cmd_t make_cmd(input int go, input int up, input int speed);
		pad_cmd_t c;
		c.go    = (go != 0);
		c.up    = (up != 0);
		c.speed = (speed != 0);
		return c;
	endfunction

	task automatic load_golden();
		int    fd;
		int    n;
		string line;
		int    v [COLS];
		fd = $fopen("test/pong_golden.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open the golden file test/pong_golden.txt");
			errors++;
		end
		else
		begin
			while (!$feof(fd) && n_seg < MAX_SEG)
			begin
				void'($fgets(line, fd));
				n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
					v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7],
					v[8], v[9], v[10], v[11], v[12], v[13], v[14]);
				if (n == COLS) // comment and blank lines fall out here
				begin
					for (int i = 0; i < COLS; i++)
						gold[n_seg][i] = v[i];
					n_seg++;
				end
			end
			$fclose(fd);
			if (n_seg == 0)
			begin
				$display("the golden file holds no segments");
				errors++;
			end
		end
	endtask

	// one four-phase transfer with all sampling on the falling edge
	task automatic take_pixel(output pixel_t px);
		int wait_n;
		@(negedge clk);
		while (!req)
			@(negedge clk);
		px = pixel;
		wait_n = $urandom_range(3, 0);
		repeat (wait_n) @(negedge clk);
		ack = 1'b1;
		@(negedge clk);
		while (req)
			@(negedge clk);
		wait_n = $urandom_range(3, 0);
		repeat (wait_n) @(negedge clk);
		ack = 1'b0; // release so the next request may follow
	endtask

	// 48 erase then 48 draw pixels with sprites in ball, left, right order
	task automatic run_frame();
		pixel_t px;
		int     ox;
		int     oy;
		int     col;
		for (int phase = 0; phase < 2; phase++)
			for (int s = 0; s < 3; s++)
				for (int k = 0; k < SPRITE_PIXELS; k++)
				begin
					take_pixel(px);
					if (k == 0)
					begin
						ox = int'(px.x);
						oy = int'(px.y);
						if (s == 1)
							check("left paddle x", ox, LEFT_PAD_X);
						else if (s == 2)
							check("right paddle x", ox, RIGHT_PAD_X);
						if (phase == 0)
						begin
							check("erase x", ox, org_x[s]); // erase hits the last drawn spot
							check("erase y", oy, org_y[s]);
						end
						else
						begin
							org_x[s] = ox;
							org_y[s] = oy;
						end
					end
					if (phase == 0)
						col = int'(BG_COLOUR);
					else if (s == 0)
						col = int'(BALL_COLOUR);
					else
						col = int'(PAD_COLOUR);
					check("pixel_o.x", int'(px.x), ox + k % 4); // raster order
					check("pixel_o.y", int'(px.y), oy + k / 4);
					check("pixel_o.colour", int'(px.colour), col);
				end
	endtask

	// watchdog armed once the golden file is known
	initial
	begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("timeout, the DUT stopped handing out pixels after %0d cycles", limit_cycles);
		$display("Test failed");
		$finish;
	end

	initial
	begin
		int seg_err;
		int limit;
		void'($urandom(92870));
		reset = 1'b1;
		serve = 1'b0;
		ack   = 1'b0;
		pad_l = '0;
		pad_r = '0;
		n_seg = 0;
		errors = 0;
		checks = 0;
		limit_cycles = 0;
		org_x = '{int'(BALL_START_X), LEFT_PAD_X, RIGHT_PAD_X};
		org_y = '{int'(BALL_START_Y), int'(PAD_START_Y), int'(PAD_START_Y)};
		load_golden();
		limit = 100 + 8;
		for (int i = 0; i < n_seg; i++)
			limit += (gold[i][7] == 0) ? IDLE_CYCLES : gold[i][7] * (96 * 10 + FRAME_TICKS);
		limit_cycles = limit;
		repeat (8) @(negedge clk);
		reset = 1'b0;
		for (int i = 0; i < n_seg; i++)
		begin
			seg_err = errors;
			pad_l = make_cmd(gold[i][0], gold[i][1], gold[i][2]);
			pad_r = make_cmd(gold[i][3], gold[i][4], gold[i][5]);
			serve = (gold[i][6] != 0);
			if (gold[i][7] == 0)
				repeat (IDLE_CYCLES)
				begin
					@(negedge clk);
					check("req_o", int'(req), 0); // no request while waiting
				end
			else
				repeat (gold[i][7]) run_frame();
			check("ball x", org_x[0], gold[i][8]);
			check("ball y", org_y[0], gold[i][9]);
			check("left paddle y", org_y[1], gold[i][10]);
			check("right paddle y", org_y[2], gold[i][11]);
			check("seg_l_o", int'(seg_l), digit_segments(gold[i][12]));
			check("seg_r_o", int'(seg_r), digit_segments(gold[i][13]));
			check("game_over_o", int'(game_over), gold[i][14]);
			$display("segment %0d, %0d frames, %s", i, gold[i][7],
				(errors == seg_err) ? "ok" : "mismatch");
		end
		$display("segments %0d, checks %0d, errors %0d", n_seg, checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== test/pong_golden.txt ====
// columns: l_go l_up l_speed r_go r_up r_speed serve frames
//          then expected ball_x ball_y left_y right_y score_l score_r game_over
// frames 0 means no request may appear during the segment
// both paddles run to the walls, ball bounces off the bottom wall
1 0 1 1 1 1 1 10 136 136 136 96 0 0 0
1 0 1 1 1 1 0 51 34 234 236 0 0 0 0
// left paddle climbs to the ball row
1 1 1 0 0 0 0 14 6 206 208 0 0 0 0
// paddle bounce at x 6
0 0 0 0 0 0 0 5 16 196 208 0 0 0 0
// top wall, then a miss on the right side scores left
0 0 0 0 0 0 0 151 156 116 116 116 1 0 0
// waits for serve
0 0 0 0 0 0 0 0 156 116 116 116 1 0 0
// three misses on the left side
0 0 0 0 0 0 1 79 156 116 116 116 1 1 0
0 0 0 0 0 0 1 79 156 116 116 116 1 2 0
0 0 0 0 0 0 1 79 156 116 116 116 1 3 1
// game over ignores serve
0 0 0 0 0 0 1 0 156 116 116 116 1 3 1

// ==== pong_top.f ====
hdl/pong_pkg.sv
hdl/pong_sequencer.sv
hdl/ball_mover.sv
hdl/paddle_mover.sv
hdl/score_board.sv
hdl/pong_top.sv
test/pong_asserts.sv
test/pong_tb.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -j 0 --top-module pong_tb -f pong_top.f -o Vpong_tb
	./obj_dir/Vpong_tb | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Test passed" $(LOG) || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
